// ==== rtl/cache_geom_pkg.sv ====
package cache_geom_pkg;

  localparam int LINE_COUNT = 8;
  localparam int INDEX_W = 3;
  localparam int TAG_W = 27;

  // tag / index / byte offset split used for lookups
  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [1:0]         offset;
  } addr_fields_t;

  // word address plus byte position within the word
  typedef struct packed {
    logic [TAG_W+INDEX_W-1:0] word;
    logic [1:0]               byte_off;
  } addr_word_t;

  typedef union packed {
    addr_fields_t fields;
    addr_word_t   words;
  } cache_addr_t;

endpackage

// ==== rtl/access_pkg.sv ====
package access_pkg;

  localparam int BYTE_W = 8;
  localparam int WORD_BYTES = 4;
  localparam int WORD_W = WORD_BYTES * BYTE_W;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // second word states only visited for unaligned accesses
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    CHECK0 = 3'd1,
    FILL0  = 3'd2,
    CHECK1 = 3'd3,
    FILL1  = 3'd4,
    DONE   = 3'd5
  } ctrl_state_e;

endpackage

// ==== rtl/cache_ifs.sv ====
`timescale 1ns/1ps

interface req_if
  import cache_geom_pkg::*;
  import access_pkg::*;
();
  logic              start;
  op_e               op;
  cache_addr_t       addr0;
  cache_addr_t       addr1;
  logic [1:0]        byte_off;
  logic              split;
  logic [WORD_W-1:0] wdata;
  logic              busy;

  modport decoder (output start, op, addr0, addr1, byte_off, split, wdata, input busy);
  modport consumer (input start, op, addr0, addr1, byte_off, split, wdata, output busy);
endinterface

interface line_if
  import cache_geom_pkg::*;
  import access_pkg::*;
();
  logic [INDEX_W-1:0] rd_index0;
  logic [INDEX_W-1:0] rd_index1;
  logic               wr_en;
  logic [INDEX_W-1:0] wr_index;
  logic [TAG_W-1:0]   wr_tag;
  logic [WORD_W-1:0]  wr_data;
  logic [TAG_W-1:0]   tag0;
  logic               valid0;
  logic [WORD_W-1:0]  data0;
  logic [TAG_W-1:0]   tag1;
  logic               valid1;
  logic [WORD_W-1:0]  data1;

  modport ctrl (output rd_index0, rd_index1, wr_en, wr_index, wr_tag, wr_data,
                input tag0, valid0, data0, tag1, valid1, data1);
  modport store (input rd_index0, rd_index1, wr_en, wr_index, wr_tag, wr_data,
                 output tag0, valid0, data0, tag1, valid1, data1);
endinterface

// ==== rtl/access_decode.sv ====
`timescale 1ns/1ps

module access_decode
  import cache_geom_pkg::*;
  import access_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [WORD_W-1:0] address,
  input  logic [WORD_W-1:0] data_in,
  input  logic              write_enable,
  input  logic              read_enable,
  req_if.decoder            req
);

  cache_addr_t req_addr;
  logic        accept;

  // strobes only count while the controller is free
  assign accept = !req.busy && (write_enable || read_enable);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      req.start <= 1'b0;
    else
      req.start <= accept;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_addr  <= address;
      req.wdata <= data_in;
      // write wins over read
      req.op    <= write_enable ? OP_WRITE : OP_READ;
    end
  end

  // addr1 may roll into the next tag
  always_comb
  begin
    req.addr0 = {req_addr.words.word, 2'b00};
    req.addr1 = {req_addr.words.word + 1'b1, 2'b00};
  end

  assign req.byte_off = req_addr.words.byte_off;
  assign req.split = |req_addr.words.byte_off;

endmodule

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl
  import access_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  req_if.consumer           req,
  line_if.ctrl              line,
  input  logic [WORD_W-1:0] fetch_read_data,
  output logic [WORD_W-1:0] fetch_address,
  output logic [WORD_W-1:0] fetch_write_data,
  output logic              fetch_write_enable,
  output logic              data_ready,
  output logic [WORD_W-1:0] word0,
  output logic [WORD_W-1:0] word1,
  input  logic [WORD_W-1:0] merged0,
  input  logic [WORD_W-1:0] merged1,
  input  logic [WORD_W-1:0] rdata,
  output logic [WORD_W-1:0] data_out
);

  ctrl_state_e state;
  logic        is_write;
  logic        hit0;
  logic        hit1;

  assign is_write = (req.op == OP_WRITE);
  assign hit0 = line.valid0 && (line.tag0 == req.addr0.fields.tag);
  assign hit1 = line.valid1 && (line.tag1 == req.addr1.fields.tag);
  assign req.busy = req.start || (state != IDLE);

  assign line.rd_index0 = req.addr0.fields.index;
  assign line.rd_index1 = req.addr1.fields.index;

  // during a fill the bus word is the current content
  assign word0 = (state == FILL0) ? fetch_read_data : line.data0;
  assign word1 = (state == FILL1) ? fetch_read_data : line.data1;

  // merged words equal the plain words on reads
  always_comb
  begin
    line.wr_en    = 1'b0;
    line.wr_index = req.addr0.fields.index;
    line.wr_tag   = req.addr0.fields.tag;
    line.wr_data  = merged0;
    case (state)
      CHECK0: line.wr_en = is_write && hit0;
      FILL0:  line.wr_en = 1'b1;
      CHECK1, FILL1:
      begin
        line.wr_en    = (state == FILL1) || (is_write && hit1);
        line.wr_index = req.addr1.fields.index;
        line.wr_tag   = req.addr1.fields.tag;
        line.wr_data  = merged1;
      end
      default: line.wr_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state              <= IDLE;
      fetch_write_enable <= 1'b0;
      data_ready         <= 1'b0;
    end
    else
    begin
      data_ready <= 1'b0;
      case (state)
        IDLE:
        begin
          fetch_write_enable <= 1'b0;
          if (req.start)
            state <= CHECK0;
        end
        CHECK0:
        begin
          fetch_write_enable <= is_write && hit0;
          if (!hit0)
            state <= FILL0;
          else
            state <= req.split ? CHECK1 : DONE;
        end
        FILL0:
        begin
          fetch_write_enable <= is_write;
          state <= req.split ? CHECK1 : DONE;
        end
        CHECK1:
        begin
          // a pending word0 store leaves the bus on this edge
          fetch_write_enable <= is_write && hit1;
          state <= hit1 ? DONE : FILL1;
        end
        FILL1:
        begin
          fetch_write_enable <= is_write;
          state <= DONE;
        end
        DONE:
        begin
          fetch_write_enable <= 1'b0;
          data_ready <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    case (state)
      CHECK0:
      begin
        fetch_address    <= req.addr0;
        fetch_write_data <= merged0;
      end
      FILL0: fetch_write_data <= merged0;
      CHECK1:
      begin
        fetch_address    <= req.addr1;
        fetch_write_data <= merged1;
      end
      FILL1: fetch_write_data <= merged1;
      DONE:
      begin
        if (!is_write)
          data_out <= rdata;
      end
      default: ;
    endcase
  end

endmodule

// ==== rtl/line_store.sv ====
`timescale 1ns/1ps

module line_store
  import cache_geom_pkg::*;
  import access_pkg::*;
(
  input logic   clk,
  input logic   reset,
  line_if.store line
);

  logic [TAG_W-1:0]      tag_mem [LINE_COUNT];
  logic [WORD_W-1:0]     data_mem [LINE_COUNT];
  logic [LINE_COUNT-1:0] valid;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      valid <= '0;
    else if (line.wr_en)
      valid[line.wr_index] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (line.wr_en)
    begin
      tag_mem[line.wr_index]  <= line.wr_tag;
      data_mem[line.wr_index] <= line.wr_data;
    end
  end

  // independent lookups for both words
  assign line.tag0   = tag_mem[line.rd_index0];
  assign line.valid0 = valid[line.rd_index0];
  assign line.data0  = data_mem[line.rd_index0];
  assign line.tag1   = tag_mem[line.rd_index1];
  assign line.valid1 = valid[line.rd_index1];
  assign line.data1  = data_mem[line.rd_index1];

endmodule

// ==== rtl/byte_align.sv ====
`timescale 1ns/1ps

module byte_align
  import access_pkg::*;
(
  input  logic [1:0]        byte_off,
  input  op_e               op,
  input  logic [WORD_W-1:0] wdata,
  input  logic [WORD_W-1:0] word0,
  input  logic [WORD_W-1:0] word1,
  output logic [WORD_W-1:0] rdata,
  output logic [WORD_W-1:0] merged0,
  output logic [WORD_W-1:0] merged1
);

  logic [2*WORD_W-1:0] pair;
  logic [2*WORD_W-1:0] shifted;
  logic [2*WORD_W-1:0] lane_mask;
  logic [2*WORD_W-1:0] store_bits;
  logic [2*WORD_W-1:0] merged_pair;
  logic [5:0]          shift;

  assign shift = 6'(byte_off * BYTE_W);

  // little endian so word1 sits above word0
  assign pair = {word1, word0};
  assign shifted = pair >> shift;
  assign rdata = shifted[WORD_W-1:0];

  // lanes touched by the store
  assign lane_mask = {{WORD_W{1'b0}}, {WORD_W{1'b1}}} << shift;
  assign store_bits = {{WORD_W{1'b0}}, wdata} << shift;

  assign merged_pair = (op == OP_WRITE) ? ((pair & ~lane_mask) | store_bits) : pair;

  assign merged0 = merged_pair[WORD_W-1:0];
  assign merged1 = merged_pair[2*WORD_W-1:WORD_W];

endmodule

// ==== rtl/cache_top.sv ====
`timescale 1ns/1ps

module cache_top
  import access_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [WORD_W-1:0] address,
  input  logic [WORD_W-1:0] data_in,
  input  logic              write_enable,
  input  logic              read_enable,
  output logic              data_ready,
  output logic [WORD_W-1:0] data_out,
  output logic [WORD_W-1:0] fetch_address,
  output logic [WORD_W-1:0] fetch_write_data,
  output logic              fetch_write_enable,
  input  logic [WORD_W-1:0] fetch_read_data
);

  req_if  req_bus ();
  line_if line_bus ();

  logic [WORD_W-1:0] word0;
  logic [WORD_W-1:0] word1;
  logic [WORD_W-1:0] merged0;
  logic [WORD_W-1:0] merged1;
  logic [WORD_W-1:0] rdata;

  access_decode u_decode (
    .clk          (clk),
    .reset        (reset),
    .address      (address),
    .data_in      (data_in),
    .write_enable (write_enable),
    .read_enable  (read_enable),
    .req          (req_bus.decoder)
  );

  cache_ctrl u_ctrl (
    .clk                (clk),
    .reset              (reset),
    .req                (req_bus.consumer),
    .line               (line_bus.ctrl),
    .fetch_read_data    (fetch_read_data),
    .fetch_address      (fetch_address),
    .fetch_write_data   (fetch_write_data),
    .fetch_write_enable (fetch_write_enable),
    .data_ready         (data_ready),
    .word0              (word0),
    .word1              (word1),
    .merged0            (merged0),
    .merged1            (merged1),
    .rdata              (rdata),
    .data_out           (data_out)
  );

  line_store u_lines (
    .clk   (clk),
    .reset (reset),
    .line  (line_bus.store)
  );

  byte_align u_align (
    .byte_off (req_bus.byte_off),
    .op       (req_bus.op),
    .wdata    (req_bus.wdata),
    .word0    (word0),
    .word1    (word1),
    .rdata    (rdata),
    .merged0  (merged0),
    .merged1  (merged1)
  );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset drops on the eighth falling edge
  initial
  begin
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== dv/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb
  import cache_geom_pkg::*;
  import access_pkg::*;
();

  localparam int TIMEOUT = 20;
  localparam int MEM_WORDS = 64;

  logic              clk;
  logic              reset;
  logic [WORD_W-1:0] address;
  logic [WORD_W-1:0] data_in;
  logic              write_enable;
  logic              read_enable;
  logic              data_ready;
  logic [WORD_W-1:0] data_out;
  logic [WORD_W-1:0] fetch_address;
  logic [WORD_W-1:0] fetch_write_data;
  logic              fetch_write_enable;
  logic [WORD_W-1:0] fetch_read_data;

  logic [WORD_W-1:0] mem [MEM_WORDS];
  logic [BYTE_W-1:0] ref_bytes [MEM_WORDS*4];
  logic [TAG_W-1:0]  ref_tag [LINE_COUNT];
  logic              ref_valid [LINE_COUNT];
  logic [31:0]       seed;
  string             test_name;
  int                errors;
  int                checks;
  int                test_errors;
  int                test_checks;

  tb_clock clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  cache_top dut (
    .clk                (clk),
    .reset              (reset),
    .address            (address),
    .data_in            (data_in),
    .write_enable       (write_enable),
    .read_enable        (read_enable),
    .data_ready         (data_ready),
    .data_out           (data_out),
    .fetch_address      (fetch_address),
    .fetch_write_data   (fetch_write_data),
    .fetch_write_enable (fetch_write_enable),
    .fetch_read_data    (fetch_read_data)
  );

  // small memory so that upper address bits alias
  assign fetch_read_data = mem[fetch_address[7:2]];

  always @(posedge clk)
  begin
    if (fetch_write_enable)
      mem[fetch_address[7:2]] <= fetch_write_data;
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {seed[15:0], seed[31:16]};
  endfunction

  function automatic logic [31:0] random_address(input logic aligned);
    logic [31:0] r;
    r = next_random();
    r = {22'h0, r[9:0]};
    if (aligned)
      r[1:0] = 2'b00;
    return r;
  endfunction

  // little endian with byte addresses wrapping like the memory
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] word;
    for (int i = 0; i < 4; i++)
      word[8*i +: 8] = ref_bytes[8'(addr + i)];
    return word;
  endfunction

  function automatic void update_reference(input logic [31:0] addr, input logic [31:0] data);
    for (int i = 0; i < 4; i++)
      ref_bytes[8'(addr + i)] = data[8*i +: 8];
  endfunction

  // words looked up plus misses as the cache allocates on every access
  function automatic int count_lookups(input logic [31:0] addr);
    cache_addr_t a;
    int          words;
    int          misses;
    a = addr;
    words = (a.words.byte_off != 2'b00) ? 2 : 1;
    misses = 0;
    a.words.byte_off = 2'b00;
    for (int w = 0; w < words; w++)
    begin
      if (!ref_valid[a.fields.index] || ref_tag[a.fields.index] != a.fields.tag)
      begin
        misses++;
        ref_valid[a.fields.index] = 1'b1;
        ref_tag[a.fields.index] = a.fields.tag;
      end
      a.words.word = a.words.word + 1'b1;
    end
    return words + misses;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    test_checks++;
    if (actual !== expected)
    begin
      errors++;
      test_errors++;
      $display("CHECK FAILED %s %s: expected %08h actual %08h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic report_test();
    $display("%s: %0d checks, %0d failed", test_name, test_checks, test_errors);
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end while (reset !== 1'b0 && cycles < TIMEOUT);
    if (reset !== 1'b0)
    begin
      errors++;
      test_errors++;
      $display("reset was still asserted after %0d cycles", TIMEOUT);
    end
  endtask

  // starts on a falling edge and may strobe once more while busy
  task automatic run_access(input logic is_write, input logic [31:0] addr,
                            input logic [31:0] data, input logic drop,
                            input logic [31:0] drop_addr, input logic [31:0] drop_data);
    logic [31:0] expected;
    int          expected_cycles;
    int          cycles;
    expected = expected_word(addr);
    expected_cycles = 3 + count_lookups(addr);
    if (is_write)
      update_reference(addr, data);
    address = addr;
    data_in = data;
    write_enable = is_write;
    read_enable = !is_write;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
      write_enable = drop && (cycles == 1);
      read_enable = 1'b0;
      if (write_enable)
      begin
        address = drop_addr;
        data_in = drop_data;
      end
    end while (!data_ready && cycles < TIMEOUT);
    if (!data_ready)
    begin
      errors++;
      test_errors++;
      $display("%s: data_ready did not arrive within %0d cycles of the strobe at %08h",
               test_name, TIMEOUT, addr);
    end
    else
    begin
      check_value("latency", expected_cycles, cycles);
      if (!is_write)
        check_value($sformatf("read %08h", addr), expected, data_out);
    end
  endtask

  task automatic compare_memory();
    for (int i = 0; i < MEM_WORDS; i++)
      check_value($sformatf("memory word %0d", i), expected_word(32'(i * 4)), mem[i]);
  endtask

  initial
  begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    address = '0;
    data_in = '0;
    write_enable = 1'b0;
    read_enable = 1'b0;
    seed = 32'he6506a81;
    errors = 0;
    checks = 0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem[i] = {~8'(i), 8'(i * 5 + 3), 8'(i) ^ 8'ha5, 8'(i)};
      for (int k = 0; k < 4; k++)
        ref_bytes[4*i + k] = mem[i][8*k +: 8];
    end
    for (int i = 0; i < LINE_COUNT; i++)
      ref_valid[i] = 1'b0;

    start_test("reset state");
    wait_reset_release();
    check_value("data_ready", 1'b0, data_ready);
    check_value("fetch_write_enable", 1'b0, fetch_write_enable);
    report_test();

    start_test("aligned reads");
    for (int i = 0; i < 40; i++)
      run_access(1'b0, random_address(1'b1), '0, 1'b0, '0, '0);
    report_test();

    start_test("unaligned reads");
    // index wraps with tag carry and a memory wrap
    run_access(1'b0, 32'h0000_001d, '0, 1'b0, '0, '0);
    run_access(1'b0, 32'h0000_003f, '0, 1'b0, '0, '0);
    run_access(1'b0, 32'h0000_03fe, '0, 1'b0, '0, '0);
    for (int i = 0; i < 37; i++)
    begin
      a = random_address(1'b0);
      if (a[1:0] == 2'b00)
        a[1:0] = 2'b10;
      run_access(1'b0, a, '0, 1'b0, '0, '0);
    end
    report_test();

    start_test("writes and readback");
    for (int i = 0; i < 60; i++)
    begin
      r = next_random();
      run_access(r[4], random_address(r[9]), next_random(), 1'b0, '0, '0);
    end
    compare_memory();
    report_test();

    start_test("tag conflicts");
    a = random_address(1'b0);
    for (int i = 0; i < 24; i++)
    begin
      // second half shares the memory word as well
      b = (i < 12) ? (a ^ 32'h0000_0120) : (a ^ 32'h0000_0100);
      r = next_random();
      run_access(r[6], (i % 2 == 0) ? a : b, next_random(), 1'b0, '0, '0);
    end
    compare_memory();
    report_test();

    start_test("dropped strobe");
    for (int i = 0; i < 6; i++)
    begin
      a = random_address(1'b0);
      b = random_address(1'b0);
      r = next_random();
      run_access(r[3], a, next_random(), 1'b1, b, next_random());
      run_access(1'b0, b, '0, 1'b0, '0, '0);
    end
    compare_memory();
    report_test();

    $display("total: %0d checks, %0d failed", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/cache_geom_pkg.sv
rtl/access_pkg.sv
rtl/cache_ifs.sv
rtl/access_decode.sv
rtl/cache_ctrl.sv
rtl/line_store.sv
rtl/byte_align.sv
rtl/cache_top.sv
dv/tb_clock.sv
dv/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache_subsystem

sources:
  - rtl/cache_geom_pkg.sv
  - rtl/access_pkg.sv
  - rtl/cache_ifs.sv
  - rtl/access_decode.sv
  - rtl/cache_ctrl.sv
  - rtl/line_store.sv
  - rtl/byte_align.sv
  - rtl/cache_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/cache_tb.sv
